/* design/opl_cfg_pkg.sv */
//**************************************************
// sizing package: datapath widths and the default
// bank and slot counts of the operator engine.
//**************************************************

package opl_cfg_pkg;

    // phase accumulator and phase increment.
    localparam int PHASE_ACC_WIDTH = 20;

    // envelope attenuation, all ones is silent.
    localparam int ENV_WIDTH = 9;

    localparam int WS_WIDTH = 3;      // waveform select.
    localparam int OP_OUT_WIDTH = 13; // signed operator output.
    localparam int SAMPLE_WIDTH = 16; // signed mixed sample.

    // default array size.
    localparam int DEFAULT_NUM_BANKS = 2;
    localparam int DEFAULT_NUM_SLOTS = 4;

endpackage

/* design/opl_wave_pkg.sv */
//**************************************************
// waveform package: waveform codes, lookup table
// widths, output full scale and lane latency.
//**************************************************

package opl_wave_pkg;

    // waveform codes.
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_SINE           = 3'd0;
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_HALF_SINE      = 3'd1;
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_ABS_SINE       = 3'd2;
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_QUARTER_SINE   = 3'd3;
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_ALT_SINE       = 3'd4;
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_ALT_ABS_SINE   = 3'd5;
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_SQUARE         = 3'd6;
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] WS_DERIVED_SQUARE = 3'd7;

    // opl2 only knows the first four waveforms.
    localparam logic [opl_cfg_pkg::WS_WIDTH-1:0] OPL2_WS_MASK = 3'b011;

    localparam int LOG_SIN_WIDTH = 12; // log-sine entry.
    localparam int EXP_WIDTH = 10;     // exponent entry.

    // output magnitude at zero attenuation, last exponent entry is 1018.
    localparam int FULL_SCALE = (1024 + 1018) * 2;

    // slot strobe to lane output.
    localparam int LANE_LATENCY = 6;

endpackage

/* design/wave_tables.sv */
//**************************************************
// log-sine and exponent lookup tables, filled at
// elaboration and read combinationally.
//**************************************************
`timescale 1ns/1ps

module wave_tables (
    input  logic [7:0]                             theta,
    output logic [opl_wave_pkg::LOG_SIN_WIDTH-1:0] log_sin,
    input  logic [7:0]                             exp_in,
    output logic [opl_wave_pkg::EXP_WIDTH-1:0]     exp_out
);
    localparam int  LSW = opl_wave_pkg::LOG_SIN_WIDTH;
    localparam int  EXW = opl_wave_pkg::EXP_WIDTH;
    localparam real PI  = 3.14159265358979;

    // -log2(sin) over a quarter wave, in 1/256 steps.
    function automatic logic [255:0][LSW-1:0] build_log_sin();
        logic [255:0][LSW-1:0] rom;
        real                   s;
        for (int i = 0; i < 256; i++) begin
            s      = $sin((i + 0.5) * PI / 512.0);
            rom[i] = LSW'($rtoi(-$ln(s) / $ln(2.0) * 256.0 + 0.5));
        end
        return rom;
    endfunction

    // 1024 * (2^(i/256) - 1).
    function automatic logic [255:0][EXW-1:0] build_exp();
        logic [255:0][EXW-1:0] rom;
        real                   e;
        for (int i = 0; i < 256; i++) begin
            e      = ($pow(2.0, i / 256.0) - 1.0) * 1024.0;
            rom[i] = EXW'($rtoi(e + 0.5));
        end
        return rom;
    endfunction

    localparam logic [255:0][LSW-1:0] LOG_SIN_ROM = build_log_sin();
    localparam logic [255:0][EXW-1:0] EXP_ROM     = build_exp();

    assign log_sin = LOG_SIN_ROM[theta];
    assign exp_out = EXP_ROM[exp_in];

endmodule

/* design/slot_sequencer.sv */
//**************************************************
// slot sequencer: per-slot settings store, key-on
// capture and the per-sample slot sweep.
//**************************************************
`timescale 1ns/1ps

module slot_sequencer #(
    parameter int NUM_BANKS = opl_cfg_pkg::DEFAULT_NUM_BANKS,
    parameter int NUM_SLOTS = opl_cfg_pkg::DEFAULT_NUM_SLOTS,
    localparam int BANK_WIDTH = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1,
    localparam int SLOT_WIDTH = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                sample_tick,
    input  logic                                                cfg_we,
    input  logic [BANK_WIDTH-1:0]                               cfg_bank,
    input  logic [SLOT_WIDTH-1:0]                               cfg_slot,
    input  logic [opl_cfg_pkg::PHASE_ACC_WIDTH-1:0]             cfg_phase_inc,
    input  logic [opl_cfg_pkg::WS_WIDTH-1:0]                    cfg_ws,
    input  logic [opl_cfg_pkg::ENV_WIDTH-1:0]                   cfg_env,
    input  logic                                                cfg_key_on,
    output logic                                                slot_strobe,
    output logic [SLOT_WIDTH-1:0]                               slot_num,
    output logic [NUM_BANKS-1:0][opl_cfg_pkg::PHASE_ACC_WIDTH-1:0] lane_phase_inc,
    output logic [NUM_BANKS-1:0][opl_cfg_pkg::WS_WIDTH-1:0]     lane_ws,
    output logic [NUM_BANKS-1:0][opl_cfg_pkg::ENV_WIDTH-1:0]    lane_env,
    output logic [NUM_BANKS-1:0]                                lane_key_on_pulse
);
    logic [opl_cfg_pkg::PHASE_ACC_WIDTH-1:0] phase_inc_q [NUM_BANKS][NUM_SLOTS];
    logic [opl_cfg_pkg::WS_WIDTH-1:0]        ws_q [NUM_BANKS][NUM_SLOTS];
    logic [opl_cfg_pkg::ENV_WIDTH-1:0]       env_q [NUM_BANKS][NUM_SLOTS];
    logic                                    key_on_q [NUM_BANKS][NUM_SLOTS];
    logic                                    key_pend_q [NUM_BANKS][NUM_SLOTS];
    logic                                    sweep_next; // a slot goes out next cycle.
    logic [SLOT_WIDTH-1:0]                   next_slot;

    // a tick restarts the sweep at slot 0, otherwise step until the last slot.
    assign next_slot  = sample_tick ? '0 : SLOT_WIDTH'(slot_num + 1'b1);
    assign sweep_next = sample_tick ||
                        (slot_strobe && slot_num != SLOT_WIDTH'(NUM_SLOTS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_strobe <= 1'b0;
            slot_num    <= '0;
        end else begin
            slot_strobe <= sweep_next;
            if (sweep_next)
                slot_num <= next_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    phase_inc_q[b][s] <= '0;
                    ws_q[b][s]        <= '0;
                    env_q[b][s]       <= '1; // silent.
                    key_on_q[b][s]    <= 1'b0;
                    key_pend_q[b][s]  <= 1'b0;
                end
            end
            lane_key_on_pulse <= '0;
        end else begin
            // a pending key-on is handed out once, with its slot.
            for (int b = 0; b < NUM_BANKS; b++) begin
                lane_key_on_pulse[b] <= sweep_next && key_pend_q[b][next_slot];
                if (sweep_next)
                    key_pend_q[b][next_slot] <= 1'b0;
            end
            if (cfg_we) begin
                phase_inc_q[cfg_bank][cfg_slot] <= cfg_phase_inc;
                ws_q[cfg_bank][cfg_slot]        <= cfg_ws;
                env_q[cfg_bank][cfg_slot]       <= cfg_env;
                key_on_q[cfg_bank][cfg_slot]    <= cfg_key_on;
                if (cfg_key_on && !key_on_q[cfg_bank][cfg_slot])
                    key_pend_q[cfg_bank][cfg_slot] <= 1'b1; // rising key edge.
            end
        end
    end

    // settings of the next slot, all banks side by side.
    always_ff @(posedge clk) begin
        if (sweep_next) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                lane_phase_inc[b] <= phase_inc_q[b][next_slot];
                lane_ws[b]        <= ws_q[b][next_slot];
                lane_env[b]       <= env_q[b][next_slot];
            end
        end
    end

endmodule

/* design/phase_generator.sv */
//**************************************************
// phase generator lane: per-slot phase accumulator,
// odd-period tracking, log-sine to linear conversion
// and the eight waveform rules.
//**************************************************
`timescale 1ns/1ps

module phase_generator #(
    parameter int NUM_SLOTS = opl_cfg_pkg::DEFAULT_NUM_SLOTS,
    localparam int SLOT_WIDTH = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        opl3_mode,
    input  logic                                        slot_strobe,
    input  logic [SLOT_WIDTH-1:0]                       slot_num,
    input  logic [opl_cfg_pkg::PHASE_ACC_WIDTH-1:0]     phase_inc,
    input  logic [opl_cfg_pkg::WS_WIDTH-1:0]            ws,
    input  logic [opl_cfg_pkg::ENV_WIDTH-1:0]           env,
    input  logic                                        key_on_pulse,
    output logic signed [opl_cfg_pkg::OP_OUT_WIDTH-1:0] out,
    output logic                                        out_valid
);
    localparam int LAT        = opl_wave_pkg::LANE_LATENCY;
    localparam int PAW        = opl_cfg_pkg::PHASE_ACC_WIDTH;
    localparam int WSW        = opl_cfg_pkg::WS_WIDTH;
    localparam int OPW        = opl_cfg_pkg::OP_OUT_WIDTH;
    localparam int LSW        = opl_wave_pkg::LOG_SIN_WIDTH;
    localparam int GAIN_WIDTH = LSW + 1;
    localparam int MAG_WIDTH  = $clog2(opl_wave_pkg::FULL_SCALE + 1);

    logic [LAT:1]                              strobe_p;
    logic [LAT:1][WSW-1:0]                     ws_p;
    logic [3:1][SLOT_WIDTH-1:0]                slot_p;
    logic [2:1][PAW-1:0]                       inc_p;
    logic [2:1]                                key_p;
    logic [5:1][opl_cfg_pkg::ENV_WIDTH-1:0]    env_p;
    logic [WSW-1:0]                            ws_m;
    logic [PAW-1:0]                            phase_mem [NUM_SLOTS];
    logic                                      msb_mem [NUM_SLOTS];
    logic                                      odd_mem [NUM_SLOTS];
    logic [PAW-1:0]                            phase_p3, phase_p4, phase_p5, phase_p6;
    logic                                      odd_p3, odd_p4, odd_p5, odd_p6;
    logic [7:0]                                theta;
    logic [LSW-1:0]                            log_sin, log_sin_p5, ws7_p5;
    logic [GAIN_WIDTH-1:0]                     gain_p5, gain_p6;
    logic [opl_wave_pkg::EXP_WIDTH-1:0]        exp_out;
    logic [MAG_WIDTH-1:0]                      mag;
    logic signed [OPW-1:0]                     raw, raw_abs, raw_odd;

    assign ws_m = opl3_mode ? ws : (ws & opl_wave_pkg::OPL2_WS_MASK);

    always_ff @(posedge clk) begin
        if (!rst_n)
            strobe_p <= '0;
        else
            strobe_p <= {strobe_p[LAT-1:1], slot_strobe};
    end

    // slot context travels alongside the strobe.
    always_ff @(posedge clk) begin
        ws_p   <= {ws_p[LAT-1:1], ws_m};
        slot_p <= {slot_p[2:1], slot_num};
        inc_p  <= {inc_p[1], phase_inc};
        key_p  <= {key_p[1], key_on_pulse};
        env_p  <= {env_p[4:1], env};
    end

    // stage 3: new phase, twice the rate for the alternating waves.
    always_ff @(posedge clk) begin
        if (key_p[2])
            phase_p3 <= '0;
        else if (ws_p[2] == opl_wave_pkg::WS_ALT_SINE ||
                 ws_p[2] == opl_wave_pkg::WS_ALT_ABS_SINE)
            phase_p3 <= phase_mem[slot_p[2]] + (inc_p[2] << 1);
        else
            phase_p3 <= phase_mem[slot_p[2]] + inc_p[2];
    end

    // a wrap of the phase msb flips the odd-period flag.
    assign odd_p3 = (msb_mem[slot_p[3]] && !phase_p3[PAW-1]) ?
                    !odd_mem[slot_p[3]] : odd_mem[slot_p[3]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                phase_mem[s] <= '0;
                msb_mem[s]   <= 1'b0;
                odd_mem[s]   <= 1'b0;
            end
        end else if (strobe_p[3]) begin
            phase_mem[slot_p[3]] <= phase_p3;
            msb_mem[slot_p[3]]   <= phase_p3[PAW-1];
            odd_mem[slot_p[3]]   <= odd_p3;
        end
    end

    // quarter-wave index, mirrored in the second and fourth quadrant.
    assign theta = phase_p4[PAW-2] ? ~phase_p4[PAW-3 -: 8] : phase_p4[PAW-3 -: 8];

    always_ff @(posedge clk) begin
        phase_p4   <= phase_p3;
        odd_p4     <= odd_p3;
        phase_p5   <= phase_p4;
        odd_p5     <= odd_p4;
        log_sin_p5 <= log_sin;
        // derived square: a linear ramp, muted by the top bit in quadrants 1 and 2.
        ws7_p5     <= {phase_p4[PAW-1] ^ phase_p4[PAW-2],
                       (phase_p4[PAW-1] ? ~phase_p4[PAW-3 -: 8] : phase_p4[PAW-3 -: 8]),
                       3'b000};
        phase_p6   <= phase_p5;
        odd_p6     <= odd_p5;
        gain_p6    <= gain_p5;
    end

    // log value plus attenuation times 8.
    always_comb begin
        case (ws_p[5])
            opl_wave_pkg::WS_SQUARE:         gain_p5 = GAIN_WIDTH'({env_p[5], 3'b000});
            opl_wave_pkg::WS_DERIVED_SQUARE: gain_p5 = ws7_p5 + {env_p[5], 3'b000};
            default:                         gain_p5 = log_sin_p5 + {env_p[5], 3'b000};
        endcase
    end

    wave_tables i_tables (
        .theta   (theta),
        .log_sin (log_sin),
        .exp_in  (~gain_p6[7:0]),
        .exp_out (exp_out)
    );

    // mantissa from the exponent table, integer part of the log as a shift.
    assign mag     = MAG_WIDTH'({1'b1, exp_out, 1'b0}) >> gain_p6[GAIN_WIDTH-1:8];
    assign raw     = phase_p6[PAW-1] ? ~OPW'(mag) : OPW'(mag);
    assign raw_abs = raw[OPW-1] ? ~raw : raw;
    assign raw_odd = odd_p6 ? raw : '0;

    always_comb begin
        case (ws_p[LAT])
            opl_wave_pkg::WS_HALF_SINE:    out = raw[OPW-1] ? '0 : raw;
            opl_wave_pkg::WS_ABS_SINE:     out = raw_abs;
            opl_wave_pkg::WS_QUARTER_SINE: out = phase_p6[PAW-2] ? '0 : raw_abs;
            opl_wave_pkg::WS_ALT_SINE:     out = raw_odd;
            opl_wave_pkg::WS_ALT_ABS_SINE: out = raw_odd[OPW-1] ? ~raw_odd : raw_odd;
            default:                       out = raw; // sine and both squares.
        endcase
    end

    assign out_valid = strobe_p[LAT];

endmodule

/* design/operator_mixer.sv */
//**************************************************
// operator mixer: per-sample sum of all lanes with
// saturation and the sample pulse.
//**************************************************
`timescale 1ns/1ps

module operator_mixer #(
    parameter int NUM_BANKS = opl_cfg_pkg::DEFAULT_NUM_BANKS
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic [NUM_BANKS-1:0][opl_cfg_pkg::OP_OUT_WIDTH-1:0] lane_out,
    input  logic                                               lane_valid,
    output logic signed [opl_cfg_pkg::SAMPLE_WIDTH-1:0]        sample,
    output logic                                               sample_valid
);
    localparam int SW        = opl_cfg_pkg::SAMPLE_WIDTH;
    localparam int ACC_WIDTH = SW + 8;
    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = ACC_WIDTH'((2 ** (SW - 1)) - 1);
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

    logic signed [ACC_WIDTH-1:0] lane_sum;
    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] acc_next;
    logic signed [SW-1:0]        sat;
    logic                        valid_d;

    always_comb begin
        lane_sum = '0;
        for (int b = 0; b < NUM_BANKS; b++)
            lane_sum += ACC_WIDTH'($signed(lane_out[b]));
    end

    // first valid slot of a sweep starts from zero.
    assign acc_next = (valid_d ? acc : '0) + lane_sum;

    always_comb begin
        if (acc_next > SAT_MAX)
            sat = SAT_MAX[SW-1:0];
        else if (acc_next < SAT_MIN)
            sat = SAT_MIN[SW-1:0];
        else
            sat = acc_next[SW-1:0];
    end

    always_ff @(posedge clk) begin
        if (lane_valid)
            acc <= acc_next;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
            sample  <= '0;
        end else begin
            valid_d <= lane_valid;
            if (lane_valid)
                sample <= sat; // running total, final once the sweep ends.
        end
    end

    assign sample_valid = valid_d && !lane_valid; // end of the sweep.

endmodule

/* design/opl_operator_top.sv */
//**************************************************
// operator engine top: sequencer, one phase
// generator lane per bank and the output mixer.
//**************************************************
`timescale 1ns/1ps

module opl_operator_top #(
    parameter int NUM_BANKS = opl_cfg_pkg::DEFAULT_NUM_BANKS,
    parameter int NUM_SLOTS = opl_cfg_pkg::DEFAULT_NUM_SLOTS,
    localparam int BANK_WIDTH = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1,
    localparam int SLOT_WIDTH = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        opl3_mode,
    input  logic                                        sample_tick,
    input  logic                                        cfg_we,
    input  logic [BANK_WIDTH-1:0]                       cfg_bank,
    input  logic [SLOT_WIDTH-1:0]                       cfg_slot,
    input  logic [opl_cfg_pkg::PHASE_ACC_WIDTH-1:0]     cfg_phase_inc,
    input  logic [opl_cfg_pkg::WS_WIDTH-1:0]            cfg_ws,
    input  logic [opl_cfg_pkg::ENV_WIDTH-1:0]           cfg_env,
    input  logic                                        cfg_key_on,
    output logic signed [opl_cfg_pkg::SAMPLE_WIDTH-1:0] sample,
    output logic                                        sample_valid
);
    logic                                                 slot_strobe;
    logic [SLOT_WIDTH-1:0]                                slot_num;
    logic [NUM_BANKS-1:0][opl_cfg_pkg::PHASE_ACC_WIDTH-1:0] lane_phase_inc;
    logic [NUM_BANKS-1:0][opl_cfg_pkg::WS_WIDTH-1:0]      lane_ws;
    logic [NUM_BANKS-1:0][opl_cfg_pkg::ENV_WIDTH-1:0]     lane_env;
    logic [NUM_BANKS-1:0]                                 lane_key_on_pulse;
    logic [NUM_BANKS-1:0][opl_cfg_pkg::OP_OUT_WIDTH-1:0]  lane_out;
    logic [NUM_BANKS-1:0]                                 lane_valid; // lanes run in lockstep.

    slot_sequencer #(
        .NUM_BANKS (NUM_BANKS),
        .NUM_SLOTS (NUM_SLOTS)
    ) i_sequencer (
        .clk, .rst_n, .sample_tick,
        .cfg_we, .cfg_bank, .cfg_slot, .cfg_phase_inc, .cfg_ws, .cfg_env, .cfg_key_on,
        .slot_strobe, .slot_num,
        .lane_phase_inc, .lane_ws, .lane_env, .lane_key_on_pulse
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_lane
        phase_generator #(
            .NUM_SLOTS (NUM_SLOTS)
        ) i_lane (
            .clk, .rst_n, .opl3_mode, .slot_strobe, .slot_num,
            .phase_inc    (lane_phase_inc[g]),
            .ws           (lane_ws[g]),
            .env          (lane_env[g]),
            .key_on_pulse (lane_key_on_pulse[g]),
            .out          (lane_out[g]),
            .out_valid    (lane_valid[g])
        );
    end

    operator_mixer #(
        .NUM_BANKS (NUM_BANKS)
    ) i_mixer (
        .clk, .rst_n, .lane_out,
        .lane_valid (lane_valid[0]),
        .sample, .sample_valid
    );

endmodule

/* sim/tb_clock_gen.sv */
//**************************************************
// testbench clock and synchronous reset source.
//**************************************************
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released away from the active edge.
    end

endmodule

/* sim/opl_operator_tb.sv */
//**************************************************
// directed testbench for the operator engine with five
// tests, a watchdog and the closing result line.
//**************************************************
`timescale 1ns/1ps

module opl_operator_tb;
    localparam int NUM_BANKS   = opl_cfg_pkg::DEFAULT_NUM_BANKS;
    localparam int NUM_SLOTS   = opl_cfg_pkg::DEFAULT_NUM_SLOTS;
    localparam int BANK_WIDTH  = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int SLOT_WIDTH  = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int NUM_OPS     = NUM_BANKS * NUM_SLOTS;
    localparam int PAW         = opl_cfg_pkg::PHASE_ACC_WIDTH;
    localparam int SW          = opl_cfg_pkg::SAMPLE_WIDTH;
    localparam int FS          = opl_wave_pkg::FULL_SCALE;
    localparam int SAT_MAX     = 2 ** (SW - 1) - 1;
    localparam int QUIET_LO    = -(NUM_OPS - 1); // each silent slot gives 0 or -1.
    localparam int TICK_CYCLES = 32;
    localparam int SAMPLE_LATENCY = NUM_SLOTS + 7; // tick to sample pulse.
    localparam int TOTAL_TICKS = 50;
    localparam int WATCHDOG_CYCLES = TOTAL_TICKS * TICK_CYCLES + 400;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    opl3_mode;
    logic                                    sample_tick;
    logic                                    cfg_we;
    logic [BANK_WIDTH-1:0]                   cfg_bank;
    logic [SLOT_WIDTH-1:0]                   cfg_slot;
    logic [PAW-1:0]                          cfg_phase_inc;
    logic [opl_cfg_pkg::WS_WIDTH-1:0]        cfg_ws;
    logic [opl_cfg_pkg::ENV_WIDTH-1:0]       cfg_env;
    logic                                    cfg_key_on;
    logic signed [SW-1:0]                    sample;
    logic                                    sample_valid;
    int                                      errors;
    int                                      checks;
    int                                      seed;

    tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(5)) i_clk_gen (.clk, .rst_n);

    opl_operator_top i_dut (
        .clk, .rst_n, .opl3_mode, .sample_tick,
        .cfg_we, .cfg_bank, .cfg_slot, .cfg_phase_inc, .cfg_ws, .cfg_env, .cfg_key_on,
        .sample, .sample_valid
    );

    // square wave is full scale in the first half period and one's complement below.
    function automatic int square_level(logic [PAW-1:0] phase);
        return phase[PAW-1] ? -FS - 1 : FS;
    endfunction

    function automatic int saturate(int value);
        if (value > SAT_MAX)
            return SAT_MAX;
        if (value < -SAT_MAX - 1)
            return -SAT_MAX - 1;
        return value;
    endfunction

    task automatic check_range(input int value, input int lo, input int hi, input int tick);
        checks++;
        if (value < lo || value > hi) begin
            errors++;
            $display("Error: sample = 0x%04h at tick %0d, expected 0x%04h to 0x%04h",
                     value[15:0], tick, lo[15:0], hi[15:0]);
        end
    endtask

    // op numbers run bank by bank as bank * NUM_SLOTS + slot.
    task automatic write_slot(input int op, input logic [PAW-1:0] inc,
                              input logic [opl_cfg_pkg::WS_WIDTH-1:0] ws,
                              input logic [opl_cfg_pkg::ENV_WIDTH-1:0] env, input logic key);
        @(negedge clk);
        cfg_we        = 1'b1;
        cfg_bank      = BANK_WIDTH'(op / NUM_SLOTS);
        cfg_slot      = SLOT_WIDTH'(op % NUM_SLOTS);
        cfg_phase_inc = inc;
        cfg_ws        = ws;
        cfg_env       = env;
        cfg_key_on    = key;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic silence_all();
        for (int op = 0; op < NUM_OPS; op++)
            write_slot(op, '0, opl_wave_pkg::WS_SINE, '1, 1'b0);
    endtask

    // one sample period of TICK_CYCLES with the sample taken while sample_valid is high.
    task automatic run_tick(output int value);
        int waited;
        @(negedge clk);
        sample_tick = 1'b1;
        @(negedge clk);
        sample_tick = 1'b0;
        waited = 1;
        while (!sample_valid && waited < TICK_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (!sample_valid) begin
            errors++;
            $display("sample_valid did not arrive within %0d cycles of the tick", TICK_CYCLES);
        end else if (waited != SAMPLE_LATENCY) begin
            errors++;
            $display("Error: sample_valid latency = 0x%0h cycles, expected 0x%0h",
                     waited, SAMPLE_LATENCY);
        end
        value = sample;
        while (waited < TICK_CYCLES) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic reset_silence();
        int value;
        repeat (2 * TICK_CYCLES) begin
            @(negedge clk);
            if (sample_valid) begin
                errors++;
                $display("sample_valid pulsed before any sample tick");
            end
        end
        checks++;
        if (sample !== '0) begin
            errors++;
            $display("Error: sample = 0x%04h after reset, expected 0x0000", sample);
        end
        for (int n = 0; n < 4; n++) begin
            run_tick(value);
            check_range(value, -NUM_OPS, 0, n);
        end
    endtask

    task automatic square_phase_tracking();
        logic [PAW-1:0] inc;
        int             value;
        int             level;
        silence_all();
        inc = PAW'($urandom);
        write_slot(6, inc, opl_wave_pkg::WS_SQUARE, '0, 1'b1);
        for (int n = 0; n < 12; n++) begin
            run_tick(value);
            level = square_level(PAW'(n * inc)); // phase restarts at the key-on sweep.
            check_range(value, level + QUIET_LO, level, n);
        end
    endtask

    task automatic half_sine_clamp();
        logic [PAW-1:0] inc;
        int             value;
        silence_all();
        inc = PAW'($urandom);
        write_slot(1, inc, opl_wave_pkg::WS_HALF_SINE, '0, 1'b1);
        for (int n = 0; n < 12; n++) begin
            run_tick(value);
            check_range(value, QUIET_LO, SAT_MAX, n);
            if (PAW'(n * inc) >> (PAW - 1))
                check_range(value, QUIET_LO, 0, n); // negative half is clamped.
        end
    endtask

    task automatic opl2_masking();
        logic [PAW-1:0] inc;
        int             value;
        int             level;
        silence_all();
        @(negedge clk);
        opl3_mode = 1'b0;
        inc = PAW'($urandom);
        write_slot(3, inc, opl_wave_pkg::WS_SQUARE, '0, 1'b1);
        for (int n = 0; n < 8; n++) begin
            run_tick(value);
            check_range(value, QUIET_LO, SAT_MAX, n);
        end
        @(negedge clk);
        opl3_mode = 1'b1;
        for (int n = 8; n < 16; n++) begin
            run_tick(value);
            level = square_level(PAW'(n * inc));
            check_range(value, level + QUIET_LO, level, n);
        end
    endtask

    task automatic key_on_restart();
        logic [PAW-1:0] incs [NUM_OPS];
        int             value;
        int             total;
        silence_all();
        for (int op = 0; op < NUM_OPS; op++) begin
            incs[op] = PAW'($urandom);
            write_slot(op, incs[op], opl_wave_pkg::WS_SQUARE, '0, 1'b1);
        end
        for (int n = 0; n < 6; n++) begin
            if (n == 4) begin
                for (int op = 0; op < NUM_OPS; op++) begin
                    write_slot(op, incs[op], opl_wave_pkg::WS_SQUARE, '0, 1'b0);
                    write_slot(op, incs[op], opl_wave_pkg::WS_SQUARE, '0, 1'b1);
                end
            end
            run_tick(value);
            total = 0;
            for (int op = 0; op < NUM_OPS; op++)
                total += square_level(PAW'((n % 4) * incs[op]));
            check_range(value, saturate(total), saturate(total), n);
        end
    endtask

    initial begin
        seed          = 32'hcc;
        seed          = $urandom(seed);
        errors        = 0;
        checks        = 0;
        opl3_mode     = 1'b1;
        sample_tick   = 1'b0;
        cfg_we        = 1'b0;
        cfg_bank      = '0;
        cfg_slot      = '0;
        cfg_phase_inc = '0;
        cfg_ws        = '0;
        cfg_env       = '1;
        cfg_key_on    = 1'b0;
        @(posedge rst_n);
        reset_silence();
        square_phase_tracking();
        half_sine_clamp();
        opl2_masking();
        key_on_restart();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog sized to all sample periods plus the slot writes.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* Bender.yml */
package:
  name: opl_operator

sources:
  - design/opl_cfg_pkg.sv
  - design/opl_wave_pkg.sv
  - design/wave_tables.sv
  - design/slot_sequencer.sv
  - design/phase_generator.sv
  - design/operator_mixer.sv
  - design/opl_operator_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/opl_operator_tb.sv

/* verilog.f */
design/opl_cfg_pkg.sv
design/opl_wave_pkg.sv
design/wave_tables.sv
design/slot_sequencer.sv
design/phase_generator.sv
design/operator_mixer.sv
design/opl_operator_top.sv
sim/tb_clock_gen.sv
sim/opl_operator_tb.sv
